//--- files.f
hdl/tx_pkg.sv
hdl/tx_fifo.sv
hdl/tx_serializer.sv
hdl/tx_mmr.sv
hdl/tx_buffer_top.sv
test/tx_buffer_tb.sv

//--- hdl/tx_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module tx_buffer_top #(
    parameter int fifo_depth = 16
) (
    input  logic                       app_clk,
    input  logic                       aresetn,

    // axi4-lite slave
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [tx_pkg::addr_w-1:0]  awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [tx_pkg::data_w-1:0]  wdata,
    output logic                       bvalid,
    input  logic                       bready,
    output logic [1:0]                 bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [tx_pkg::addr_w-1:0]  araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [tx_pkg::data_w-1:0]  rdata,
    output logic [1:0]                 rresp,

    // link
    input  logic                       tx_odd,
    output logic [7:0]                 tx_data,
    output logic                       tx_charisk
);

    logic                                    start;
    logic                                    ready;
    logic                                    done;
    logic                                    full;
    logic                                    empty;
    logic                                    wr_en;
    logic [tx_pkg::data_w+tx_pkg::isk_w-1:0] wr_data;
    logic                                    rd_en;
    logic [tx_pkg::data_w+tx_pkg::isk_w-1:0] rd_data;

    tx_mmr u_mmr (
        .app_clk (app_clk),
        .aresetn (aresetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .start   (start),
        .ready   (ready),
        .done    (done),
        .full    (full),
        .empty   (empty),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    tx_fifo #(
        .depth (fifo_depth)
    ) u_fifo (
        .app_clk (app_clk),
        .aresetn (aresetn),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (full),
        .empty   (empty)
    );

    tx_serializer u_ser (
        .app_clk    (app_clk),
        .aresetn    (aresetn),
        .start      (start),
        .tx_odd     (tx_odd),
        .empty      (empty),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .ready      (ready),
        .done       (done),
        .tx_data    (tx_data),
        .tx_charisk (tx_charisk)
    );

endmodule

`default_nettype wire

//--- hdl/tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tx_fifo #(
    parameter int depth = 16
) (
    input  logic                                    app_clk,
    input  logic                                    aresetn,
    input  logic                                    wr_en,
    input  logic [tx_pkg::data_w+tx_pkg::isk_w-1:0] wr_data,
    input  logic                                    rd_en,
    output logic [tx_pkg::data_w+tx_pkg::isk_w-1:0] rd_data,
    output logic                                    full,
    output logic                                    empty
);

    localparam int aw = $clog2(depth);
    localparam int ew = tx_pkg::data_w + tx_pkg::isk_w;   // word plus K flags

    logic [ew-1:0] mem [depth];
    logic [aw:0]   wr_ptr;   // extra msb tells wrap
    logic [aw:0]   rd_ptr;
    logic          do_wr;
    logic          do_rd;

    if ((depth & (depth - 1)) != 0 || depth < 2) begin : g_depth_check
        $error("tx_fifo depth must be a power of two");
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

    assign do_wr = wr_en && !full;    // overflow ignored
    assign do_rd = rd_en && !empty;

    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge app_clk) begin
        if (do_wr)
            mem[wr_ptr[aw-1:0]] <= wr_data;
    end

    // read port registered so data trails rd_en by one cycle
    always_ff @(posedge app_clk) begin
        if (do_rd)
            rd_data <= mem[rd_ptr[aw-1:0]];
    end

    // the serializer only pops when a word is waiting
    a_no_underflow: assert property (@(posedge app_clk) disable iff (!aresetn)
        rd_en |-> !empty);

endmodule

`default_nettype wire

//--- hdl/tx_mmr.sv
`timescale 1ns/1ps
`default_nettype none

module tx_mmr (
    input  logic                       app_clk,
    input  logic                       aresetn,

    // write address channel
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [tx_pkg::addr_w-1:0]  awaddr,
    // write data channel
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [tx_pkg::data_w-1:0]  wdata,
    // write response channel
    output logic                       bvalid,
    input  logic                       bready,
    output logic [1:0]                 bresp,
    // read address channel
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [tx_pkg::addr_w-1:0]  araddr,
    // read data channel
    output logic                       rvalid,
    input  logic                       rready,
    output logic [tx_pkg::data_w-1:0]  rdata,
    output logic [1:0]                 rresp,

    // serializer side
    output logic                       start,
    input  logic                       ready,
    input  logic                       done,

    // fifo side
    input  logic                       full,
    input  logic                       empty,
    output logic                       wr_en,
    output logic [tx_pkg::data_w+tx_pkg::isk_w-1:0] wr_data
);

    // write channel state
    logic                      aw_held;
    logic                      w_held;
    logic [tx_pkg::addr_w-1:0] aw_addr;
    logic [tx_pkg::data_w-1:0] w_data;

    // read channel state
    logic                      ar_held;
    logic [tx_pkg::addr_w-1:0] ar_addr;

    // control register and payload staging
    logic                      cr_start;
    logic [tx_pkg::data_w-1:0] data_in;
    logic [tx_pkg::isk_w-1:0]  isk_in;
    logic                      data_upd;
    logic                      isk_upd;

    logic [tx_pkg::data_w-1:0] sr_word;
    logic [tx_pkg::data_w-1:0] cr_word;
    logic                      wr_fire;

    assign bresp   = 2'b00;   // always OKAY
    assign rresp   = 2'b00;
    assign start   = cr_start;
    assign wr_fire = bvalid && bready;

    always_comb begin
        sr_word = '0;
        sr_word[tx_pkg::sr_empty_bit] = empty;
        sr_word[tx_pkg::sr_full_bit]  = full;
        sr_word[tx_pkg::sr_ready_bit] = ready;
        cr_word = '0;
        cr_word[tx_pkg::cr_start_bit] = cr_start;
    end

    // push once both halves of the entry have been written
    assign wr_en   = data_upd && isk_upd;
    assign wr_data = {data_in, isk_in};

    // read channel
    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            arready <= 1'b0;
            ar_held <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= 1'b0;
            if (arvalid && !ar_held) begin
                ar_held <= 1'b1;
                arready <= 1'b1;
            end
            if (ar_held && !rvalid) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid  <= 1'b0;
                ar_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge app_clk) begin
        if (arvalid && !ar_held)
            ar_addr <= araddr;
        if (ar_held && !rvalid) begin
            case (ar_addr)
                tx_pkg::reg_sr: rdata <= sr_word;
                tx_pkg::reg_cr: rdata <= cr_word;
                default:        rdata <= '0;   // unmapped or write only
            endcase
        end
    end

    // write channel
    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && !aw_held) begin
                aw_held <= 1'b1;
                awready <= 1'b1;
            end
            if (wvalid && !w_held) begin
                w_held <= 1'b1;
                wready <= 1'b1;
            end
            if (aw_held && w_held && !bvalid) begin
                bvalid <= 1'b1;
            end else if (wr_fire) begin
                bvalid  <= 1'b0;
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end
        end
    end

    always_ff @(posedge app_clk) begin
        if (awvalid && !aw_held)
            aw_addr <= awaddr;
        if (wvalid && !w_held)
            w_data <= wdata;
    end

    // register actions take effect on the response handshake
    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            cr_start <= 1'b0;
            data_upd <= 1'b0;
            isk_upd  <= 1'b0;
        end else begin
            if (wr_en) begin
                data_upd <= 1'b0;
                isk_upd  <= 1'b0;
            end
            if (wr_fire) begin
                case (aw_addr)
                    tx_pkg::reg_cr:   cr_start <= w_data[tx_pkg::cr_start_bit];
                    tx_pkg::reg_cr_s: cr_start <= cr_start | w_data[tx_pkg::cr_start_bit];
                    tx_pkg::reg_cr_c: cr_start <= cr_start & ~w_data[tx_pkg::cr_start_bit];
                    tx_pkg::reg_data: data_upd <= 1'b1;
                    tx_pkg::reg_isk:  isk_upd  <= 1'b1;
                    default: ;
                endcase
            end
            // start drops once the serializer finishes
            if (done)
                cr_start <= 1'b0;
        end
    end

    always_ff @(posedge app_clk) begin
        if (wr_fire && aw_addr == tx_pkg::reg_data)
            data_in <= w_data;
        if (wr_fire && aw_addr == tx_pkg::reg_isk)
            isk_in <= w_data[tx_pkg::isk_w-1:0];
    end

    // the push strobe lasts a single cycle
    a_push_strobe: assert property (@(posedge app_clk) disable iff (!aresetn)
        wr_en |=> !wr_en);

    // a response stays up until the master takes it
    a_bvalid_hold: assert property (@(posedge app_clk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

//--- hdl/tx_pkg.sv
`default_nettype none

package tx_pkg;

    // bus and payload widths
    localparam int data_w = 32;
    localparam int isk_w  = 4;    // one K flag per byte
    localparam int addr_w = 8;

    // register offsets
    localparam logic [addr_w-1:0] reg_sr   = 8'h00;  // status, read only
    localparam logic [addr_w-1:0] reg_cr   = 8'h04;  // control
    localparam logic [addr_w-1:0] reg_cr_s = 8'h08;  // control bit set
    localparam logic [addr_w-1:0] reg_cr_c = 8'h0C;  // control bit clear
    localparam logic [addr_w-1:0] reg_data = 8'h14;  // payload word
    localparam logic [addr_w-1:0] reg_isk  = 8'h18;  // K flags of the word

    // status bits
    localparam int sr_empty_bit = 0;
    localparam int sr_full_bit  = 1;
    localparam int sr_ready_bit = 2;

    // control bits
    localparam int cr_start_bit = 0;

endpackage

`default_nettype wire

//--- hdl/tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_serializer (
    input  logic                                    app_clk,
    input  logic                                    aresetn,
    input  logic                                    start,
    input  logic                                    tx_odd,
    input  logic                                    empty,
    output logic                                    rd_en,
    input  logic [tx_pkg::data_w+tx_pkg::isk_w-1:0] rd_data,
    output logic                                    ready,
    output logic                                    done,
    output logic [7:0]                              tx_data,
    output logic                                    tx_charisk
);

    typedef enum logic [1:0] {
        st_idle,
        st_even,
        st_odd
    } state_t;

    state_t     state;
    state_t     state_nx;
    logic [1:0] byte_cnt;
    logic [7:0] cur_byte;
    logic       cur_isk;

    // byte n of the word sits above the K flags
    assign cur_byte = rd_data[tx_pkg::isk_w + 8*byte_cnt +: 8];
    assign cur_isk  = rd_data[byte_cnt];

    assign tx_data    = (state == st_odd) ? cur_byte : 8'h00;
    assign tx_charisk = (state == st_odd) ? cur_isk : 1'b0;

    assign ready = (state == st_idle);
    assign rd_en = (state == st_even) && (byte_cnt == 2'd0);   // pop at word start

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: begin
                // nothing to send keeps us idle even with start set
                if (start && tx_odd && !empty)
                    state_nx = st_even;
            end
            st_even: state_nx = st_odd;
            st_odd: begin
                if (byte_cnt == 2'd3 && empty)
                    state_nx = st_idle;
                else
                    state_nx = st_even;
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            state    <= st_idle;
            byte_cnt <= 2'd0;
            done     <= 1'b0;
        end else begin
            state <= state_nx;
            done  <= (state == st_odd) && (state_nx == st_idle);   // last byte out
            if (state == st_odd)
                byte_cnt <= byte_cnt + 2'd1;   // wraps to 0 after byte 3
        end
    end

    // bytes only go out on the odd link phase
    a_odd_phase: assert property (@(posedge app_clk) disable iff (!aresetn)
        state == st_odd |-> tx_odd);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tx_buffer_tb \
    -f files.f -o tx_sim && ./obj_dir/tx_sim || exit 1

//--- test/tx_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tx_buffer_tb;

    localparam int depth = 16;
    localparam logic [1:0] resp_okay = 2'b00;

    logic                      app_clk;
    logic                      aresetn;
    logic                      awvalid;
    logic                      awready;
    logic [tx_pkg::addr_w-1:0] awaddr;
    logic                      wvalid;
    logic                      wready;
    logic [tx_pkg::data_w-1:0] wdata;
    logic                      bvalid;
    logic                      bready;
    logic [1:0]                bresp;
    logic                      arvalid;
    logic                      arready;
    logic [tx_pkg::addr_w-1:0] araddr;
    logic                      rvalid;
    logic                      rready;
    logic [tx_pkg::data_w-1:0] rdata;
    logic [1:0]                rresp;
    logic                      tx_odd;
    logic [7:0]                tx_data;
    logic                      tx_charisk;

    // parsed stimulus lines
    string                     cmd_q[$];
    string                     label_q[$];
    logic [31:0]               arg_a_q[$];
    logic [31:0]               arg_b_q[$];

    // words expected on the link in send order
    logic [tx_pkg::data_w-1:0] data_q[$];
    logic [tx_pkg::isk_w-1:0]  isk_q[$];
    logic [tx_pkg::data_w-1:0] data_hold;
    logic [tx_pkg::isk_w-1:0]  isk_hold;
    logic                      data_pend;
    logic                      isk_pend;
    int                        byte_idx;

    string                     test_name;
    logic [31:0]               lcg_state;
    int                        cycles;
    int                        cycle_limit;

    tx_buffer_top #(.fifo_depth(depth)) u_tx_buffer_top (.*);

    always #2 app_clk = ~app_clk;

    always @(posedge app_clk) begin
        #1;
        tx_odd = ~tx_odd;   // link phase flips each cycle
    end

    always @(posedge app_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the bus or the link stopped responding", cycles);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [tx_pkg::data_w-1:0] exp,
                              input logic [tx_pkg::data_w-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp_data, input logic exp_k,
                              input logic [7:0] act_data, input logic act_k);
        if (act_data !== exp_data || act_k !== exp_k) begin
            $display("error %s: expected %h k=%b actual %h k=%b",
                     name, exp_data, exp_k, act_data, act_k);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("error %s: expected resp %b actual resp %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic axi_write(input logic [tx_pkg::addr_w-1:0] addr,
                             input logic [tx_pkg::data_w-1:0] data);
        logic aw_ok;
        logic w_ok;
        logic b_ok;
        aw_ok   = 1'b0;
        w_ok    = 1'b0;
        b_ok    = 1'b0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!b_ok) begin
            @(negedge app_clk);
            aw_ok = aw_ok | awready;
            w_ok  = w_ok | wready;
            b_ok  = bvalid;   // response taken on the next edge
            if (b_ok)
                check_resp(test_name, resp_okay, bresp);
            @(posedge app_clk);
            #1;
            if (aw_ok)
                awvalid = 1'b0;
            if (w_ok)
                wvalid = 1'b0;
        end
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [tx_pkg::addr_w-1:0] addr,
                            output logic [tx_pkg::data_w-1:0] data);
        logic ar_ok;
        logic r_ok;
        ar_ok   = 1'b0;
        r_ok    = 1'b0;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!r_ok) begin
            @(negedge app_clk);
            ar_ok = ar_ok | arready;
            r_ok  = rvalid;
            data  = rdata;
            if (r_ok)
                check_resp(test_name, resp_okay, rresp);
            @(posedge app_clk);
            #1;
            if (ar_ok)
                arvalid = 1'b0;
        end
        rready = 1'b0;
    endtask

    // register write plus the expected-word bookkeeping
    task automatic write_reg(input logic [tx_pkg::addr_w-1:0] addr, input logic [31:0] data);
        axi_write(addr, data);
        if (addr == tx_pkg::reg_data) begin
            data_hold = data;
            data_pend = 1'b1;
        end
        if (addr == tx_pkg::reg_isk) begin
            isk_hold = data[tx_pkg::isk_w-1:0];
            isk_pend = 1'b1;
        end
        if (data_pend && isk_pend) begin
            if (data_q.size() < depth) begin   // full fifo loses the word
                data_q.push_back(data_hold);
                isk_q.push_back(isk_hold);
            end
            data_pend = 1'b0;
            isk_pend  = 1'b0;
        end
    endtask

    task automatic push_random(input int n);
        logic [31:0] word;
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            word      = lcg_state;
            lcg_state = lcg_next(lcg_state);
            write_reg(tx_pkg::reg_data, word);
            write_reg(tx_pkg::reg_isk, {28'd0, lcg_state[31:28]});   // high bits mix best
        end
    endtask

    task automatic expect_bytes(input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge app_clk);
            if (tx_odd && !u_tx_buffer_top.ready) begin
                if (data_q.size() == 0) begin
                    $display("a byte went out on the link with no word left to send");
                    stop_with_failure();
                end else begin
                    check_byte(test_name, data_q[0][8*byte_idx +: 8], isk_q[0][byte_idx],
                               tx_data, tx_charisk);
                    byte_idx = byte_idx + 1;
                    got      = got + 1;
                    if (byte_idx == 4) begin
                        void'(data_q.pop_front());
                        void'(isk_q.pop_front());
                        byte_idx = 0;
                    end
                end
            end else begin
                check_byte(test_name, 8'h00, 1'b0, tx_data, tx_charisk);   // quiet cycle
            end
        end
        @(posedge app_clk);
        #1;
    endtask

    initial begin
        int                        fd;
        int                        code;
        int                        total;
        string                     tok;
        string                     line;
        logic [31:0]               a;
        logic [31:0]               b;
        logic [tx_pkg::data_w-1:0] rd;
        app_clk     = 1'b0;
        aresetn     = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        tx_odd      = 1'b0;
        data_pend   = 1'b0;
        isk_pend    = 1'b0;
        byte_idx    = 0;
        lcg_state   = 32'ha077;
        cycles      = 0;
        cycle_limit = 500;
        test_name   = "setup";
        total       = 0;

        fd = $fopen("test/tx_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/tx_stim.txt");
            stop_with_failure();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            a = '0;
            b = '0;
            line = "";
            if (tok.getc(0) == "#") begin
                code = $fgets(line, fd);   // comment line
            end else begin
                if (tok == "t")
                    code = $fscanf(fd, "%s", line);
                else if (tok == "e" || tok == "p")
                    code = $fscanf(fd, "%d", a);
                else
                    code = $fscanf(fd, "%h %h", a, b);
                if (tok == "p")
                    total = total + 2 * int'(a);
                else if (tok == "e")
                    total = total + int'(a);
                else if (tok != "t")
                    total = total + 1;
                cmd_q.push_back(tok);
                label_q.push_back(line);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
            end
        end
        $fclose(fd);
        cycle_limit = 20 * total + 500;

        repeat (16) @(posedge app_clk);
        #1;
        aresetn = 1'b1;

        foreach (cmd_q[i]) begin
            if (cmd_q[i] == "t") begin
                test_name = label_q[i];
            end else if (cmd_q[i] == "w") begin
                write_reg(arg_a_q[i][tx_pkg::addr_w-1:0], arg_b_q[i]);
            end else if (cmd_q[i] == "r") begin
                axi_read(arg_a_q[i][tx_pkg::addr_w-1:0], rd);
                check_word(test_name, arg_b_q[i], rd);
            end else if (cmd_q[i] == "e") begin
                expect_bytes(int'(arg_a_q[i]));
            end else if (cmd_q[i] == "p") begin
                push_random(int'(arg_a_q[i]));
            end else begin
                $display("unknown command %s in the stimulus file", cmd_q[i]);
                stop_with_failure();
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tx_stim.txt
# t name | w offset data | r offset expected | e byte count | p word count
# offsets and data in hex, counts in decimal
t reset_values
r 00 00000005
r 04 00000000
t control_set_clear
w 04 00000001
r 04 00000001
w 0C 00000001
r 04 00000000
w 08 00000001
r 04 00000001
w 04 00000000
r 04 00000000
t readback_zero
r 08 00000000
r 0C 00000000
r 14 00000000
r 18 00000000
r 10 00000000
t data_without_isk
w 14 aabbccdd
w 14 11223344
r 00 00000005
t three_words
w 14 4433221c
w 18 00000001
w 14 bc5a3c1f
w 18 00000005
w 14 00ff7e01
w 18 0000000a
r 00 00000004
w 08 00000001
e 12
r 04 00000000
r 00 00000005
t fifo_full
p 16
r 00 00000006
p 1
r 00 00000006
w 08 00000001
e 64
r 04 00000000
r 00 00000005
